//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tcb_mem_tb \
    -f src.f --Mdir obj_dir -o tcb_mem_sim

out=$(./obj_dir/tcb_mem_sim +verilator+error+limit+1000)
echo "$out"

grep -qx "TESTS PASSED" <<< "$out"

//--- src.f
src/tcb_lite_pkg.sv
src/tcb_mem_pkg.sv
src/tcb_mem_dec.sv
src/tcb_mem_exe.sv
src/tcb_mem_rsp.sv
src/tcb_mem_top.sv
test/tcb_lite_vip_manager.sv
test/tcb_mem_properties.sv
test/tcb_mem_tb.sv

//--- src/tcb_lite_pkg.sv
package tcb_lite_pkg;

    ////////////////////////////////////////
    // bus geometry
    ////////////////////////////////////////

    // address width in bits
    localparam int unsigned ADR = 10;
    // data width in bits
    localparam int unsigned DAT = 32;
    // bytes per data word
    localparam int unsigned BYT = DAT / 8;
    // fixed response latency in cycles
    localparam int unsigned DLY = 3;

    // byte address
    typedef logic [ADR-1:0] adr_t;
    // data word
    typedef logic [DAT-1:0] dat_t;

    ////////////////////////////////////////
    // transfer size
    ////////////////////////////////////////

    // logarithmic encoding, bytes = 2**siz
    typedef enum logic [1:0] {
        SIZ_8  = 2'd0,
        SIZ_16 = 2'd1,
        SIZ_32 = 2'd2,
        SIZ_64 = 2'd3
    } siz_t;

    ////////////////////////////////////////
    // request and response
    ////////////////////////////////////////

    // request, write data in low bytes
    typedef struct packed {
        logic wen;
        adr_t adr;
        siz_t siz;
        dat_t wdt;
    } tcb_req_t;

    // response, read data in low bytes
    typedef struct packed {
        dat_t rdt;
        logic err;
    } tcb_rsp_t;

endpackage: tcb_lite_pkg

//--- src/tcb_mem_dec.sv
`timescale 1ns/1ps

module tcb_mem_dec (
    input  logic                   man,
    input  logic                   rst_n,
    input  logic                   req_vld,
    input  tcb_lite_pkg::tcb_req_t req,
    output logic                   cmd_vld,
    output tcb_mem_pkg::mem_cmd_t  cmd
);

    ////////////////////////////////////////
    // address split
    ////////////////////////////////////////

    // word index and byte offset
    tcb_mem_pkg::idx_t     idx;
    tcb_mem_pkg::off_t     off;
    // size check and lane mask
    logic                  err;
    tcb_mem_pkg::ben_t     ben_siz;
    tcb_mem_pkg::ben_t     ben;
    // lane steered write data
    tcb_lite_pkg::dat_t    wdt;
    // next command
    tcb_mem_pkg::mem_cmd_t cmd_d;

    // upper bits select the word
    assign {idx, off} = req.adr;

    ////////////////////////////////////////
    // size and alignment
    ////////////////////////////////////////

    always_comb begin
        unique case (req.siz)
            tcb_lite_pkg::SIZ_8: begin
                // any offset is fine
                ben_siz = tcb_mem_pkg::ben_t'(4'b0001);
                err     = 1'b0;
            end
            tcb_lite_pkg::SIZ_16: begin
                // halfword on even offset
                ben_siz = tcb_mem_pkg::ben_t'(4'b0011);
                err     = off[0];
            end
            tcb_lite_pkg::SIZ_32: begin
                // word only at offset 0
                ben_siz = tcb_mem_pkg::ben_t'(4'b1111);
                err     = |off;
            end
            default: begin
                // 64 bit never fits the bus
                ben_siz = '0;
                err     = 1'b1;
            end
        endcase
    end

    // move enables to addressed lanes, none on error
    assign ben = err ? '0 : tcb_mem_pkg::ben_t'(ben_siz << off);

    // low bytes up to their lanes
    assign wdt = req.wdt << {off, 3'b000};

    assign cmd_d = '{
        wen: req.wen,
        idx: idx,
        off: off,
        siz: req.siz,
        ben: ben,
        wdt: wdt,
        err: err
    };

    ////////////////////////////////////////
    // stage register
    ////////////////////////////////////////

    // valid follows every transfer
    always_ff @(posedge man or negedge rst_n) begin
        if (!rst_n) begin
            cmd_vld <= 1'b0;
        end else begin
            cmd_vld <= req_vld;
        end
    end

    // payload only on transfer
    always_ff @(posedge man) begin
        if (req_vld) begin
            cmd <= cmd_d;
        end
    end

endmodule: tcb_mem_dec

//--- src/tcb_mem_exe.sv
`timescale 1ns/1ps

module tcb_mem_exe (
    input  logic                  man,
    input  logic                  rst_n,
    input  logic                  cmd_vld,
    input  tcb_mem_pkg::mem_cmd_t cmd,
    output logic                  rd_vld,
    output tcb_lite_pkg::dat_t    rd_dat,
    output tcb_mem_pkg::off_t     rd_off,
    output tcb_lite_pkg::siz_t    rd_siz,
    output logic                  rd_err,
    output logic                  rd_wen
);

    ////////////////////////////////////////
    // storage
    ////////////////////////////////////////

    // word array, byte lanes written separately
    tcb_lite_pkg::dat_t mem [tcb_mem_pkg::DEPTH];

    // write enabled bytes
    // read same word, old value on a write
    always_ff @(posedge man) begin
        if (cmd_vld) begin
            if (cmd.wen) begin
                for (int unsigned b = 0; b < tcb_lite_pkg::BYT; b++) begin
                    if (cmd.ben[b]) begin
                        mem[cmd.idx][8*b+:8] <= cmd.wdt[8*b+:8];
                    end
                end
            end
            rd_dat <= mem[cmd.idx];
        end
    end

    ////////////////////////////////////////
    // per transfer fields
    ////////////////////////////////////////

    // valid pipeline bit
    always_ff @(posedge man or negedge rst_n) begin
        if (!rst_n) begin
            rd_vld <= 1'b0;
        end else begin
            rd_vld <= cmd_vld;
        end
    end

    // forwarded next to read data
    always_ff @(posedge man) begin
        if (cmd_vld) begin
            rd_off <= cmd.off;
            rd_siz <= cmd.siz;
            rd_err <= cmd.err;
            rd_wen <= cmd.wen;
        end
    end

endmodule: tcb_mem_exe

//--- src/tcb_mem_pkg.sv
package tcb_mem_pkg;

    ////////////////////////////////////////
    // memory geometry
    ////////////////////////////////////////

    // number of words
    localparam int unsigned DEPTH = 256;
    // word index width
    localparam int unsigned IDX = $clog2(DEPTH);
    // byte offset width
    localparam int unsigned OFF = $clog2(tcb_lite_pkg::BYT);

    // word index into the array
    typedef logic [IDX-1:0] idx_t;
    // byte offset inside a word
    typedef logic [OFF-1:0] off_t;
    // one enable per byte lane
    typedef logic [tcb_lite_pkg::BYT-1:0] ben_t;

    ////////////////////////////////////////
    // decoded command
    ////////////////////////////////////////

    // decode to execute, off/siz/err/wen
    // travel on to the result stage
    typedef struct packed {
        logic               wen;
        idx_t               idx;
        off_t               off;
        tcb_lite_pkg::siz_t siz;
        ben_t               ben;
        tcb_lite_pkg::dat_t wdt;
        logic               err;
    } mem_cmd_t;

endpackage: tcb_mem_pkg

//--- src/tcb_mem_rsp.sv
`timescale 1ns/1ps

module tcb_mem_rsp (
    input  logic                   man,
    input  logic                   rst_n,
    input  logic                   rd_vld,
    input  tcb_lite_pkg::dat_t     rd_dat,
    input  tcb_mem_pkg::off_t      rd_off,
    input  tcb_lite_pkg::siz_t     rd_siz,
    input  logic                   rd_err,
    input  logic                   rd_wen,
    output logic                   rsp_vld,
    output tcb_lite_pkg::tcb_rsp_t rsp
);

    ////////////////////////////////////////
    // lane alignment
    ////////////////////////////////////////

    // addressed byte down to lane 0
    tcb_lite_pkg::dat_t rdt_sft;
    // cut to access width
    tcb_lite_pkg::dat_t rdt_msk;
    // final read data
    tcb_lite_pkg::dat_t rdt;

    assign rdt_sft = rd_dat >> {rd_off, 3'b000};

    always_comb begin
        unique case (rd_siz)
            tcb_lite_pkg::SIZ_8:  rdt_msk = rdt_sft & tcb_lite_pkg::dat_t'(32'h0000_00ff);
            tcb_lite_pkg::SIZ_16: rdt_msk = rdt_sft & tcb_lite_pkg::dat_t'(32'h0000_ffff);
            default:              rdt_msk = rdt_sft;
        endcase
    end

    // nothing returned for writes or errors
    assign rdt = (rd_wen || rd_err) ? '0 : rdt_msk;

    ////////////////////////////////////////
    // response register
    ////////////////////////////////////////

    always_ff @(posedge man or negedge rst_n) begin
        if (!rst_n) begin
            rsp_vld <= 1'b0;
        end else begin
            rsp_vld <= rd_vld;
        end
    end

    // hold last response between transfers
    always_ff @(posedge man) begin
        if (rd_vld) begin
            rsp <= '{rdt: rdt, err: rd_err};
        end
    end

endmodule: tcb_mem_rsp

//--- src/tcb_mem_top.sv
`timescale 1ns/1ps

module tcb_mem_top (
    input  logic                   man,
    input  logic                   rst_n,
    input  logic                   req_vld,
    input  tcb_lite_pkg::tcb_req_t req,
    output logic                   rsp_vld,
    output tcb_lite_pkg::tcb_rsp_t rsp
);

    ////////////////////////////////////////
    // stage links
    ////////////////////////////////////////

    // decode to execute
    logic                  cmd_vld;
    tcb_mem_pkg::mem_cmd_t cmd;

    // execute to result
    logic                  rd_vld;
    tcb_lite_pkg::dat_t    rd_dat;
    tcb_mem_pkg::off_t     rd_off;
    tcb_lite_pkg::siz_t    rd_siz;
    logic                  rd_err;
    logic                  rd_wen;

    ////////////////////////////////////////
    // pipeline, one cycle per stage
    ////////////////////////////////////////

    // address check, lanes, enables
    tcb_mem_dec dec0 (
        .man     (man),
        .rst_n   (rst_n),
        .req_vld (req_vld),
        .req     (req),
        .cmd_vld (cmd_vld),
        .cmd     (cmd)
    );

    // array access
    tcb_mem_exe exe0 (
        .man     (man),
        .rst_n   (rst_n),
        .cmd_vld (cmd_vld),
        .cmd     (cmd),
        .rd_vld  (rd_vld),
        .rd_dat  (rd_dat),
        .rd_off  (rd_off),
        .rd_siz  (rd_siz),
        .rd_err  (rd_err),
        .rd_wen  (rd_wen)
    );

    // read alignment and response
    tcb_mem_rsp rsp0 (
        .man     (man),
        .rst_n   (rst_n),
        .rd_vld  (rd_vld),
        .rd_dat  (rd_dat),
        .rd_off  (rd_off),
        .rd_siz  (rd_siz),
        .rd_err  (rd_err),
        .rd_wen  (rd_wen),
        .rsp_vld (rsp_vld),
        .rsp     (rsp)
    );

endmodule: tcb_mem_top

//--- test/tcb_lite_vip_manager.sv
`timescale 1ns/1ps

module tcb_lite_vip_manager (
    input  logic                   man,
    input  logic                   rst_n,
    output logic                   req_vld,
    output tcb_lite_pkg::tcb_req_t req,
    input  logic                   rsp_vld,
    input  tcb_lite_pkg::tcb_rsp_t rsp
);

    ////////////////////////////////////////
    // queues and counters
    ////////////////////////////////////////

    // waiting to go on the bus
    tcb_lite_pkg::tcb_req_t req_q [$];
    // issued, waiting for compare
    tcb_lite_pkg::tcb_req_t iss_q [$];
    // sampled responses
    tcb_lite_pkg::tcb_rsp_t rsp_q [$];
    int unsigned n_req;
    int unsigned n_rsp;

    initial begin
        req_vld = 1'b0;
        req     = '0;
        n_req   = 0;
        n_rsp   = 0;
    end

    // one request per edge, idle when queue is empty
    always @(posedge man) begin
        if (rst_n && req_q.size() > 0) begin
            req_vld <= 1'b1;
            req     <= req_q.pop_front();
        end else begin
            req_vld <= 1'b0;
        end
    end

    // no back-pressure, take every response
    always @(posedge man) begin
        if (rst_n && rsp_vld) begin
            rsp_q.push_back(rsp);
            n_rsp++;
        end
    end

    ////////////////////////////////////////
    // request tasks
    ////////////////////////////////////////

    // queue without waiting
    task automatic push(input tcb_lite_pkg::tcb_req_t r);
        req_q.push_back(r);
        iss_q.push_back(r);
        n_req++;
    endtask

    // queue and wait for own response
    task automatic xfer(input logic wen, input tcb_lite_pkg::adr_t adr,
                        input tcb_lite_pkg::siz_t siz, input tcb_lite_pkg::dat_t wdt);
        int unsigned ticket;
        ticket = n_req + 1;
        push('{wen: wen, adr: adr, siz: siz, wdt: wdt});
        while (n_rsp < ticket) @(posedge man);
    endtask

    // all outstanding responses in
    task automatic drain();
        while (n_rsp < n_req) @(posedge man);
    endtask

    // per size wrappers
    task automatic wr8(input tcb_lite_pkg::adr_t adr, input tcb_lite_pkg::dat_t wdt);
        xfer(1'b1, adr, tcb_lite_pkg::SIZ_8, wdt);
    endtask
    task automatic wr16(input tcb_lite_pkg::adr_t adr, input tcb_lite_pkg::dat_t wdt);
        xfer(1'b1, adr, tcb_lite_pkg::SIZ_16, wdt);
    endtask
    task automatic wr32(input tcb_lite_pkg::adr_t adr, input tcb_lite_pkg::dat_t wdt);
        xfer(1'b1, adr, tcb_lite_pkg::SIZ_32, wdt);
    endtask
    task automatic rd8(input tcb_lite_pkg::adr_t adr);
        xfer(1'b0, adr, tcb_lite_pkg::SIZ_8, '0);
    endtask
    task automatic rd16(input tcb_lite_pkg::adr_t adr);
        xfer(1'b0, adr, tcb_lite_pkg::SIZ_16, '0);
    endtask
    task automatic rd32(input tcb_lite_pkg::adr_t adr);
        xfer(1'b0, adr, tcb_lite_pkg::SIZ_32, '0);
    endtask

endmodule: tcb_lite_vip_manager

//--- test/tcb_mem_properties.sv
`timescale 1ns/1ps

module tcb_mem_properties (
    input logic                   man,
    input logic                   rst_n,
    input logic                   req_vld,
    input logic                   rsp_vld,
    input tcb_lite_pkg::tcb_rsp_t rsp
);

    // failed assertion count, read by the testbench
    int unsigned fails = 0;

    // fixed latency
    assert property (@(posedge man) disable iff (!rst_n)
        rsp_vld == $past(req_vld, tcb_lite_pkg::DLY))
        else begin $error("rsp_vld not DLY cycles after req_vld"); fails++; end

    // known payload on a valid response
    assert property (@(posedge man) disable iff (!rst_n)
        rsp_vld |-> !$isunknown(rsp))
        else begin $error("rsp unknown while rsp_vld high"); fails++; end

    // error carries no data
    assert property (@(posedge man) disable iff (!rst_n)
        (rsp_vld && rsp.err) |-> (rsp.rdt == '0))
        else begin $error("rsp.err with nonzero rdt"); fails++; end

endmodule: tcb_mem_properties

bind tcb_mem_top tcb_mem_properties props0 (
    .man     (man),
    .rst_n   (rst_n),
    .req_vld (req_vld),
    .rsp_vld (rsp_vld),
    .rsp     (rsp)
);

//--- test/tcb_mem_tb.sv
`timescale 1ns/1ps

module tcb_mem_tb;

    // random transfers in the last test
    localparam int unsigned N_RAND = 300;
    // directed transfers after the fill
    localparam int unsigned N_DIR  = 27;
    // every transfer the run issues
    localparam int unsigned N_XFER = tcb_mem_pkg::DEPTH + N_DIR + N_RAND;

    logic                   man;
    logic                   rst_n;
    logic                   req_vld;
    tcb_lite_pkg::tcb_req_t req;
    logic                   rsp_vld;
    tcb_lite_pkg::tcb_rsp_t rsp;

    int unsigned errors = 0;
    int unsigned checks = 0;
    int unsigned tests  = 0;
    int unsigned err_mark;

    // byte shadow of the memory
    logic [7:0] shadow [tcb_mem_pkg::DEPTH*tcb_lite_pkg::BYT];

    tcb_lite_pkg::tcb_rsp_t got;
    tcb_lite_pkg::tcb_rsp_t exp;
    tcb_lite_pkg::tcb_req_t cur;

    tcb_mem_top dut0 (.man(man), .rst_n(rst_n), .req_vld(req_vld), .req(req),
                      .rsp_vld(rsp_vld), .rsp(rsp));

    tcb_lite_vip_manager mgr0 (.man(man), .rst_n(rst_n), .req_vld(req_vld), .req(req),
                               .rsp_vld(rsp_vld), .rsp(rsp));

    initial begin
        man = 1'b0;
        forever #5 man = ~man;
    end

    ////////////////////////////////////////
    // reference model and compare
    ////////////////////////////////////////

    // size and alignment rule, lane steering and zero data on write or error
    function automatic tcb_lite_pkg::tcb_rsp_t ref_model(input tcb_lite_pkg::tcb_req_t r);
        int unsigned nb;
        tcb_lite_pkg::tcb_rsp_t e;
        nb    = 1 << r.siz;
        e.rdt = '0;
        e.err = (r.siz == tcb_lite_pkg::SIZ_64) || ((int'(r.adr) % nb) != 0);
        if (!e.err) begin
            for (int unsigned b = 0; b < nb; b++) begin
                if (r.wen) begin
                    shadow[int'(r.adr) + b] = r.wdt[8*b+:8];
                end else begin
                    e.rdt[8*b+:8] = shadow[int'(r.adr) + b];
                end
            end
        end
        return e;
    endfunction

    task automatic check_rdt(input string name, input tcb_lite_pkg::dat_t g,
                             input tcb_lite_pkg::dat_t e);
        checks++;
        if (g !== e) begin
            errors++;
            $display("ERR %0t %s got %h exp %h", $time, name, g, e);
        end
    endtask

    task automatic check_err(input string name, input logic g, input logic e);
        checks++;
        if (g !== e) begin
            errors++;
            $display("ERR %0t %s got %b exp %b", $time, name, g, e);
        end
    endtask

    // response valid outside of transfers
    task automatic check_vld(input string name, input logic g, input logic e);
        checks++;
        if (g !== e) begin
            errors++;
            $display("ERR %0t %s got %b exp %b", $time, name, g, e);
        end
    endtask

    // responses come back in issue order
    initial forever begin
        @(negedge man);
        while (mgr0.rsp_q.size() > 0) begin
            got = mgr0.rsp_q.pop_front();
            cur = mgr0.iss_q.pop_front();
            exp = ref_model(cur);
            check_rdt("rsp.rdt", got.rdt, exp.rdt);
            check_err("rsp.err", got.err, exp.err);
        end
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    function automatic tcb_lite_pkg::tcb_req_t mk_req(input logic wen,
            input tcb_lite_pkg::adr_t adr, input tcb_lite_pkg::siz_t siz,
            input tcb_lite_pkg::dat_t wdt);
        return '{wen: wen, adr: adr, siz: siz, wdt: wdt};
    endfunction

    // wait for all responses and their compare
    task automatic finish_test(input string name);
        mgr0.drain();
        repeat (2) @(negedge man);
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - err_mark);
        err_mark = errors;
    endtask

    // watchdog
    initial begin
        #(N_XFER * (tcb_lite_pkg::DLY + 4) * 10 + 2000);
        $display("timeout: responses stopped arriving");
        $display("TESTS FAILED");
        $finish;
    end

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial begin
        int unsigned gap;
        tcb_lite_pkg::siz_t siz;
        tcb_lite_pkg::adr_t adr;
        void'($urandom(28789));
        rst_n    = 1'b0;
        err_mark = 0;
        // rsp_vld stays low in reset
        repeat (10) begin
            @(negedge man);
            check_vld("rsp_vld", rsp_vld, 1'b0);
        end
        @(posedge man);
        rst_n <= 1'b1;
        // and low until the first request
        repeat (5) begin
            @(negedge man);
            check_vld("rsp_vld", rsp_vld, 1'b0);
        end
        finish_test("reset");

        // fill every word with a pattern from its index
        for (int unsigned i = 0; i < tcb_mem_pkg::DEPTH; i++) begin
            mgr0.push(mk_req(1'b1, tcb_lite_pkg::adr_t'(i*4), tcb_lite_pkg::SIZ_32,
                             {8'(i), 8'(~i), 8'(i ^ 8'h5a), 8'(i + 1)}));
        end
        finish_test("fill");

        // aligned writes and reads of every size
        mgr0.wr32(10'h040, 32'hdead_beef);
        mgr0.wr8(10'h041, 32'h0000_00a5);
        mgr0.wr16(10'h042, 32'h0000_1234);
        for (int unsigned o = 0; o < 4; o++) begin
            mgr0.rd8(tcb_lite_pkg::adr_t'(10'h040 + o));
        end
        mgr0.rd16(10'h040);
        mgr0.rd16(10'h042);
        mgr0.rd32(10'h040);
        // top byte only, rest of word from the fill
        mgr0.wr8(10'h047, 32'h0000_0077);
        mgr0.rd32(10'h044);
        finish_test("aligned");

        // misaligned and 64 bit accesses leave memory untouched
        mgr0.wr16(10'h081, 32'h0000_ffff);
        mgr0.wr32(10'h082, 32'hffff_ffff);
        mgr0.xfer(1'b1, 10'h080, tcb_lite_pkg::SIZ_64, 32'hffff_ffff);
        mgr0.rd16(10'h083);
        mgr0.rd32(10'h081);
        mgr0.xfer(1'b0, 10'h080, tcb_lite_pkg::SIZ_64, '0);
        mgr0.rd32(10'h080);
        finish_test("errors");

        // back to back with a read right after a write to the same word
        mgr0.push(mk_req(1'b1, 10'h100, tcb_lite_pkg::SIZ_32, 32'h0102_0304));
        mgr0.push(mk_req(1'b0, 10'h100, tcb_lite_pkg::SIZ_32, '0));
        mgr0.push(mk_req(1'b1, 10'h101, tcb_lite_pkg::SIZ_8, 32'h0000_00ee));
        mgr0.push(mk_req(1'b0, 10'h100, tcb_lite_pkg::SIZ_32, '0));
        mgr0.push(mk_req(1'b1, 10'h102, tcb_lite_pkg::SIZ_16, 32'h0000_c0de));
        mgr0.push(mk_req(1'b0, 10'h102, tcb_lite_pkg::SIZ_16, '0));
        mgr0.push(mk_req(1'b0, 10'h103, tcb_lite_pkg::SIZ_16, '0));
        mgr0.push(mk_req(1'b0, 10'h100, tcb_lite_pkg::SIZ_32, '0));
        finish_test("back_to_back");

        // random mix that is mostly aligned
        for (int unsigned n = 0; n < N_RAND; n++) begin
            siz = tcb_lite_pkg::siz_t'(2'($urandom));
            adr = tcb_lite_pkg::adr_t'($urandom);
            if ($urandom % 4 != 0) adr = adr & ~tcb_lite_pkg::adr_t'((1 << siz) - 1);
            mgr0.push(mk_req(1'($urandom), adr, siz, $urandom));
            // idle cycles once the request is out
            gap = $urandom % 4;
            if (gap != 0) begin
                while (mgr0.req_q.size() > 0) @(posedge man);
                repeat (gap) @(posedge man);
            end
        end
        finish_test("random");

        errors = errors + dut0.props0.fails;
        $display("tests %0d checks %0d errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule: tcb_mem_tb
